// File: rtl/frame_compositor.sv
module frame_compositor (
    input  logic              clk,
    input  logic              rst_n,
    input  river_pkg::coord_t col,
    input  river_pkg::coord_t row,
    input  logic              active,
    input  logic              hsync_raw,
    input  logic              vsync_raw,
    input  logic              in_log,
    output river_pkg::color_t color,
    output logic              hsync,
    output logic              vsync
);

    import river_pkg::*;

    coord_t col_d;
    coord_t row_d;
    logic   active_d;
    logic   hsync_d;
    logic   vsync_d;
    logic   in_field;
    logic   in_river;
    logic   in_bank;
    color_t color_next;

    // match the one cycle of the log hit test
    always_ff @(posedge clk) begin
        col_d <= col;
        row_d <= row;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_d <= 1'b0;
            hsync_d  <= 1'b1;
            vsync_d  <= 1'b1;
        end else begin
            active_d <= active;
            hsync_d  <= hsync_raw;
            vsync_d  <= vsync_raw;
        end
    end

    assign in_field = (col_d >= X_OFFSET_LEFT) && (col_d < X_OFFSET_RIGHT);
    assign in_river = (row_d >= RIVER_TOP_Y) && (row_d < RIVER_BOT_Y);
    // upper bank is one block, lower bank runs to the last visible line
    assign in_bank  = ((row_d >= BANK_TOP_Y) && (row_d < BANK_TOP_Y + BLOCK_SIZE)) ||
                      ((row_d >= RIVER_BOT_Y) && (row_d < V_ACTIVE));

    always_comb begin
        if (!active_d) begin
            color_next = COLOR_BLANK;
        end else if (in_log) begin
            color_next = COLOR_LOG;
        end else if (in_river && in_field) begin
            color_next = COLOR_WATER;
        end else if (in_bank && in_field) begin
            color_next = COLOR_GRASS;
        end else begin
            color_next = COLOR_BLANK;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            color <= COLOR_BLANK;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            color <= color_next;
            hsync <= hsync_d;
            vsync <= vsync_d;
        end
    end

endmodule

// File: rtl/log_field_if.sv
interface log_field_if (
    input logic clk
);

    import river_pkg::*;

    // screen x of every log, already offset by the left playfield edge
    coord_t log_x [NUM_LANES][LOGS_PER_LANE];

    // positions only move right after the frame tick, in vertical blanking
    modport motion (
        input  clk,
        output log_x
    );

    modport render (
        input clk,
        input log_x
    );

endinterface

// File: rtl/log_motion.sv
module log_motion (
    input logic        clk,
    input logic        rst_n,
    input logic        frame_tick,
    input logic [1:0]  speed_sel,
    log_field_if.motion field
);

    import river_pkg::*;

    // lane offsets within the playfield, always below FIELD_WIDTH
    coord_t lane_off [NUM_LANES];
    coord_t off_next [NUM_LANES];

    always_comb begin
        coord_t step;
        coord_t sum;
        for (int n = 0; n < NUM_LANES; n++) begin
            step = LANE_SPEED[n] * coord_t'(speed_sel);
            sum  = lane_off[n] + step;
            if (LANE_DIR[n] == DIR_RIGHT) begin
                if (sum >= FIELD_WIDTH) begin
                    off_next[n] = sum - FIELD_WIDTH;
                end else begin
                    off_next[n] = sum;
                end
            end else if (lane_off[n] >= step) begin
                off_next[n] = lane_off[n] - step;
            end else begin
                // wrap from the left edge back to the right
                off_next[n] = lane_off[n] + FIELD_WIDTH - step;
            end
        end
    end

    // speed_sel only matters in the tick cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int n = 0; n < NUM_LANES; n++) begin
                lane_off[n] <= START_OFFSET[n];
            end
        end else if (frame_tick) begin
            for (int n = 0; n < NUM_LANES; n++) begin
                lane_off[n] <= off_next[n];
            end
        end
    end

    // log k trails log 0 by k spacings; one subtraction is enough since
    // offset plus two spacings stays below twice the field width
    always_comb begin
        coord_t pos;
        for (int n = 0; n < NUM_LANES; n++) begin
            for (int k = 0; k < LOGS_PER_LANE; k++) begin
                pos = lane_off[n] + coord_t'(k) * LOG_SPACING[n];
                if (pos >= FIELD_WIDTH) begin
                    pos = pos - FIELD_WIDTH;
                end
                field.log_x[n][k] = X_OFFSET_LEFT + pos;
            end
        end
    end

endmodule

// File: rtl/logs_gen.sv
module logs_gen (
    input  logic              clk,
    input  logic              rst_n,
    input  river_pkg::coord_t col,
    input  river_pkg::coord_t row,
    log_field_if.render       field,
    output logic              in_log
);

    import river_pkg::*;

    logic   in_field;
    logic   lane_hit [NUM_LANES];
    logic   hit;

    // right edge clips logs that run past the playfield
    assign in_field = (col >= X_OFFSET_LEFT) && (col < X_OFFSET_RIGHT);

    // each lane band is tested against the three logs of that lane
    always_comb begin
        logic in_band;
        for (int n = 0; n < NUM_LANES; n++) begin
            in_band     = (row >= RIVER_TOP_Y + coord_t'(n) * BLOCK_SIZE) &&
                          (row < RIVER_TOP_Y + coord_t'(n + 1) * BLOCK_SIZE);
            lane_hit[n] = 1'b0;
            if (in_band && in_field) begin
                for (int k = 0; k < LOGS_PER_LANE; k++) begin
                    if ((col >= field.log_x[n][k]) &&
                        (col < field.log_x[n][k] + LOG_LENGTH[n])) begin
                        lane_hit[n] = 1'b1;
                    end
                end
            end
        end
    end

    // bands are disjoint, so at most one lane can hit
    always_comb begin
        hit = 1'b0;
        for (int n = 0; n < NUM_LANES; n++) begin
            hit = hit | lane_hit[n];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_log <= 1'b0;
        end else begin
            in_log <= hit;
        end
    end

endmodule

// File: rtl/river_pkg.sv
package river_pkg;

    typedef logic [9:0] coord_t;
    typedef logic [5:0] color_t;

    // 640x480 timing, counts in pixel clocks and lines
    localparam coord_t H_ACTIVE     = 10'd640;
    localparam coord_t H_SYNC_START = 10'd656;
    localparam coord_t H_SYNC_END   = 10'd752;
    localparam coord_t H_TOTAL      = 10'd800;

    localparam coord_t V_ACTIVE     = 10'd480;
    localparam coord_t V_SYNC_START = 10'd490;
    localparam coord_t V_SYNC_END   = 10'd492;
    localparam coord_t V_TOTAL      = 10'd525;

    // playfield geometry
    localparam coord_t BLOCK_SIZE     = 10'd32;
    localparam coord_t X_OFFSET_LEFT  = 10'd96;
    localparam coord_t X_OFFSET_RIGHT = 10'd544;
    localparam coord_t FIELD_WIDTH    = 10'd448;

    localparam int NUM_LANES     = 6;
    localparam int LOGS_PER_LANE = 3;

    localparam coord_t RIVER_TOP_Y = 10'd256;
    // first row below the river, also the top of the lower bank
    localparam coord_t RIVER_BOT_Y = RIVER_TOP_Y + coord_t'(NUM_LANES) * BLOCK_SIZE;
    localparam coord_t BANK_TOP_Y  = 10'd224;

    localparam color_t COLOR_LOG   = 6'b100010;
    localparam color_t COLOR_WATER = 6'b000011;
    localparam color_t COLOR_GRASS = 6'b001100;
    localparam color_t COLOR_BLANK = 6'b000000;

    localparam logic DIR_RIGHT = 1'b1;
    localparam logic DIR_LEFT  = 1'b0;

    // lane tables, index is the lane number
    localparam coord_t LOG_LENGTH [NUM_LANES] = '{
        10'd64, 10'd96, 10'd128, 10'd64, 10'd96, 10'd128
    };
    localparam coord_t LOG_SPACING [NUM_LANES] = '{
        10'd150, 10'd150, 10'd150, 10'd150, 10'd150, 10'd150
    };
    // pixels per frame at speed_sel of 1
    localparam coord_t LANE_SPEED [NUM_LANES] = '{
        10'd1, 10'd2, 10'd1, 10'd3, 10'd2, 10'd1
    };
    localparam logic LANE_DIR [NUM_LANES] = '{
        DIR_RIGHT, DIR_LEFT, DIR_RIGHT, DIR_LEFT, DIR_RIGHT, DIR_LEFT
    };
    localparam coord_t START_OFFSET [NUM_LANES] = '{
        10'd0, 10'd40, 10'd80, 10'd120, 10'd160, 10'd200
    };

endpackage

// File: rtl/river_scene_top.sv
module river_scene_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [1:0] speed_sel,
    output logic       hsync,
    output logic       vsync,
    output logic [5:0] color
);

    import river_pkg::*;

    coord_t col;
    coord_t row;
    logic   active;
    logic   hsync_raw;
    logic   vsync_raw;
    logic   frame_tick;
    logic   in_log;

    log_field_if field_if (.clk(clk));

    vga_timing vga_timing_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .col        (col),
        .row        (row),
        .active     (active),
        .hsync_raw  (hsync_raw),
        .vsync_raw  (vsync_raw),
        .frame_tick (frame_tick)
    );

    log_motion log_motion_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .frame_tick (frame_tick),
        .speed_sel  (speed_sel),
        .field      (field_if.motion)
    );

    logs_gen logs_gen_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .col    (col),
        .row    (row),
        .field  (field_if.render),
        .in_log (in_log)
    );

    frame_compositor frame_compositor_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .col       (col),
        .row       (row),
        .active    (active),
        .hsync_raw (hsync_raw),
        .vsync_raw (vsync_raw),
        .in_log    (in_log),
        .color     (color),
        .hsync     (hsync),
        .vsync     (vsync)
    );

endmodule

// File: rtl/vga_timing.sv
module vga_timing (
    input  logic              clk,
    input  logic              rst_n,
    output river_pkg::coord_t col,
    output river_pkg::coord_t row,
    output logic              active,
    output logic              hsync_raw,
    output logic              vsync_raw,
    output logic              frame_tick
);

    import river_pkg::*;

    logic line_end;
    logic frame_end;

    assign line_end  = (col == H_TOTAL - 10'd1);
    assign frame_end = (row == V_TOTAL - 10'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
        end else if (line_end) begin
            col <= '0;
        end else begin
            col <= col + 10'd1;
        end
    end

    // row steps once per line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row <= '0;
        end else if (line_end) begin
            if (frame_end) begin
                row <= '0;
            end else begin
                row <= row + 10'd1;
            end
        end
    end

    assign active = (col < H_ACTIVE) && (row < V_ACTIVE);

    // both syncs are active low
    assign hsync_raw = !((col >= H_SYNC_START) && (col < H_SYNC_END));
    assign vsync_raw = !((row >= V_SYNC_START) && (row < V_SYNC_END));

    // first pixel of the first blank line, well away from any visible row
    assign frame_tick = (col == '0) && (row == V_ACTIVE);

endmodule

// File: run.sh
#!/bin/sh
# compile and run the river scene testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module river_scene_tb -Mdir "$BUILD_DIR" -o river_scene_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/river_scene_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0

// File: sim.f
rtl/river_pkg.sv
rtl/log_field_if.sv
rtl/vga_timing.sv
rtl/log_motion.sv
rtl/logs_gen.sv
rtl/frame_compositor.sv
rtl/river_scene_top.sv
verification/river_scene_tb.sv

// File: verification/river_scene_tb.sv
module river_scene_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import river_pkg::*;

    localparam int FRAME_TIMEOUT = 500000;

    logic       clk;
    logic       rst_n;
    logic [1:0] speed_sel;
    logic       hsync;
    logic       vsync;
    logic [5:0] color;

    // model raster state and the two stage expected pipeline
    int         h;
    int         v;
    int         model_off [NUM_LANES];
    logic [1:0] tick_speed;
    logic [5:0] exp_color1, exp_color2;
    logic       exp_hs1, exp_hs2, exp_vs1, exp_vs2;
    logic       valid1, valid2;
    int         h1, v1, h2, v2;

    logic [15:0] lfsr_state;
    int          frames_driven;
    int          hs_low;
    int          vs_lines;
    int          sig;
    int          prev_sig;
    logic        have_prev;

    river_scene_top river_scene_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .speed_sel (speed_sel),
        .hsync     (hsync),
        .vsync     (vsync),
        .color     (color)
    );

    always #4 clk = ~clk;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string msg);
        stop_with_failure($sformatf("MISMATCH at %0t: %s", $time, msg));
    endtask

    function automatic logic [15:0] galois_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic take_bit(output logic b);
        b = lfsr_state[0];
        lfsr_state = galois_step(lfsr_state);
    endtask

    // even lanes drift right, odd lanes left, wrapping inside the playfield
    function automatic int moved_offset(input int off, input int lane, input int sel);
        int step;
        int fw;
        fw = int'(FIELD_WIDTH);
        step = int'(LANE_SPEED[lane]) * sel;
        if (lane % 2 == 0) begin
            return (off + step) % fw;
        end
        return (off - step + fw) % fw;
    endfunction

    function automatic logic [5:0] expected_color(input int x, input int y);
        int lane;
        int log_left;
        if (x >= int'(H_ACTIVE) || y >= int'(V_ACTIVE)) begin
            return COLOR_BLANK;
        end
        if (x < int'(X_OFFSET_LEFT) || x >= int'(X_OFFSET_RIGHT)) begin
            return COLOR_BLANK;
        end
        if (y >= 256 && y < 448) begin
            lane = (y - 256) / 32;
            for (int k = 0; k < LOGS_PER_LANE; k++) begin
                log_left = 96 + (model_off[lane] + k * 150) % 448;
                if (x >= log_left && x < log_left + int'(LOG_LENGTH[lane])) begin
                    return COLOR_LOG;
                end
            end
            return COLOR_WATER;
        end
        if ((y >= 224 && y < 256) || y >= 448) begin
            return COLOR_GRASS;
        end
        return COLOR_BLANK;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h <= 0;
            v <= 0;
            for (int n = 0; n < NUM_LANES; n++) begin
                model_off[n] <= int'(START_OFFSET[n]);
            end
            tick_speed <= 2'd1;
            exp_color1 <= COLOR_BLANK;
            exp_color2 <= COLOR_BLANK;
            exp_hs1    <= 1'b1;
            exp_hs2    <= 1'b1;
            exp_vs1    <= 1'b1;
            exp_vs2    <= 1'b1;
            valid1     <= 1'b0;
            valid2     <= 1'b0;
            h1 <= 0;
            v1 <= 0;
            h2 <= 0;
            v2 <= 0;
        end else begin
            exp_color1 <= expected_color(h, v);
            exp_hs1    <= !(h >= 656 && h < 752);
            exp_vs1    <= !(v >= 490 && v < 492);
            valid1     <= 1'b1;
            h1 <= h;
            v1 <= v;
            exp_color2 <= exp_color1;
            exp_hs2    <= exp_hs1;
            exp_vs2    <= exp_vs1;
            valid2     <= valid1;
            h2 <= h1;
            v2 <= v1;
            if (h == 799) begin
                h <= 0;
                v <= (v == 524) ? 0 : v + 1;
            end else begin
                h <= h + 1;
            end
            // frame tick at the first pixel of line 480
            if (h == 0 && v == 480) begin
                for (int n = 0; n < NUM_LANES; n++) begin
                    model_off[n] <= moved_offset(model_off[n], n, int'(speed_sel));
                end
                tick_speed <= speed_sel;
            end
        end
    end

    // new speed mid frame; the second choice is forced to 0 to freeze a frame
    always @(posedge clk) begin : drive_speed
        logic [1:0] sel;
        logic       b;
        if (rst_n && h == 0 && v == 200) begin
            take_bit(b);
            sel[0] = b;
            take_bit(b);
            sel[1] = b;
            if (frames_driven == 1) begin
                sel = 2'd0;
            end
            speed_sel <= sel;
            frames_driven <= frames_driven + 1;
        end
    end

    always @(negedge clk) begin
        assert (color === exp_color2)
            else report_mismatch($sformatf("color %b expected %b at col %0d row %0d",
                                           color, exp_color2, h2, v2));
        assert (hsync === exp_hs2)
            else report_mismatch($sformatf("hsync %b at col %0d row %0d", hsync, h2, v2));
        assert (vsync === exp_vs2)
            else report_mismatch($sformatf("vsync %b at col %0d row %0d", vsync, h2, v2));
        if (!rst_n) begin
            assert (hsync && vsync && color == COLOR_BLANK)
                else report_mismatch("outputs not idle during reset");
        end
        if (valid2) begin
            if (!hsync) begin
                hs_low = hs_low + 1;
            end
            if (h2 == 0 && !vsync) begin
                vs_lines = vs_lines + 1;
            end
            if (h2 < 640 && v2 < 480) begin
                sig = sig * 31 + int'(color);
            end
            if (h2 == 639 && v2 == 479) begin
                // a frozen frame must repeat the previous picture
                if (have_prev && tick_speed == 2'd0) begin
                    assert (sig == prev_sig)
                        else report_mismatch("frame changed with speed_sel at 0");
                end
                prev_sig  = sig;
                have_prev = 1'b1;
                sig = 0;
            end
            if (h2 == 799) begin
                assert (hs_low == 96)
                    else report_mismatch($sformatf("hsync low for %0d cycles", hs_low));
                hs_low = 0;
                if (v2 == 524) begin
                    assert (vs_lines == 2)
                        else report_mismatch($sformatf("vsync low for %0d lines", vs_lines));
                    vs_lines = 0;
                end
            end
        end
    end

    task automatic wait_vsync_fall();
        int   cycles;
        logic prev;
        cycles = 0;
        @(negedge clk);
        prev = vsync;
        @(negedge clk);
        while (!(prev && !vsync)) begin
            if (cycles > FRAME_TIMEOUT) begin
                stop_with_failure("timed out waiting for the falling edge of vsync");
            end
            prev = vsync;
            cycles = cycles + 1;
            @(negedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        speed_sel = 2'd1;
        lfsr_state = 16'd51662;
        frames_driven = 0;
        hs_low = 0;
        vs_lines = 0;
        sig = 0;
        prev_sig = 0;
        have_prev = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        for (int f = 0; f < 4; f++) begin
            wait_vsync_fall();
        end
        $display("Test passed");
        $finish;
    end

endmodule
